// ==== design/rvfi_trace_top.sv ====
// ******************************
// RVFI trace encoder top level
// Decode, execute and Wishbone writer stages in a row
// ******************************
`timescale 1ns/1ps
`include "trace_consts.svh"

module rvfi_trace_top import trace_pkg::*; #(
  parameter logic [`TRACE_XLEN-1:0] BASE_ADDR = 32'h0000_1000
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         rvfi_valid,
  input  logic [`TRACE_XLEN-1:0]       rvfi_insn,
  input  logic [`TRACE_XLEN-1:0]       rvfi_pc_rdata,
  input  logic [`TRACE_XLEN-1:0]       rvfi_pc_wdata,
  input  logic [`TRACE_REG_AW-1:0]     rvfi_rs1_addr,
  input  logic [`TRACE_REG_AW-1:0]     rvfi_rs2_addr,
  input  logic [`TRACE_REG_AW-1:0]     rvfi_rd_addr,
  input  logic [`TRACE_XLEN-1:0]       rvfi_rs1_rdata,
  input  logic [`TRACE_XLEN-1:0]       rvfi_rs2_rdata,
  input  logic [`TRACE_XLEN-1:0]       rvfi_rd_wdata,
  input  logic [`TRACE_XLEN-1:0]       rvfi_mem_addr,
  output logic                         wb_cyc,
  output logic                         wb_stb,
  output logic                         wb_we,
  output logic [3:0]                   wb_sel,
  output logic [`TRACE_XLEN-1:0]       wb_adr,
  output logic [`TRACE_XLEN-1:0]       wb_dat_o,
  input  logic                         wb_ack,
  output logic [15:0]                  drop_count
);

  // Decode to execute
  logic                      dec_valid;
  insn_class_e               dec_class;
  access_mask_t              dec_access;
  logic [`TRACE_XLEN-1:0]    dec_insn;
  logic [`TRACE_XLEN-1:0]    dec_pc;
  logic [`TRACE_XLEN-1:0]    dec_pc_next;
  logic [`TRACE_REG_AW-1:0]  dec_rs1_addr;
  logic [`TRACE_REG_AW-1:0]  dec_rs2_addr;
  logic [`TRACE_REG_AW-1:0]  dec_rd_addr;
  logic [`TRACE_XLEN-1:0]    dec_rs1_data;
  logic [`TRACE_XLEN-1:0]    dec_rs2_data;
  logic [`TRACE_XLEN-1:0]    dec_rd_data;
  logic [`TRACE_XLEN-1:0]    dec_mem_addr;
  logic [`TRACE_CYCLE_W-1:0] dec_cycle;
  logic                      exe_ready;

  // Execute to result
  logic                      exe_valid;
  access_mask_t              exe_access;
  logic [`TRACE_XLEN-1:0]    exe_header;
  logic [`TRACE_XLEN-1:0]    exe_pc;
  logic [`TRACE_XLEN-1:0]    exe_insn;
  logic [`TRACE_XLEN-1:0]    exe_operand;
  logic [`TRACE_XLEN-1:0]    exe_rs1_data;
  logic [`TRACE_XLEN-1:0]    exe_rs2_data;
  logic [`TRACE_XLEN-1:0]    exe_rd_data;
  logic [`TRACE_XLEN-1:0]    exe_mem_addr;
  logic                      res_ready;

  trace_decode u_decode (.*);

  trace_execute u_execute (.*);

  trace_result #(
    .BASE_ADDR(BASE_ADDR)
  ) u_result (.*);

endmodule

// ==== design/trace_consts.svh ====
// ******************************
// Widths, record layout and ring buffer size of the RVFI trace encoder
// Included by the RTL files that size ports or pack the header
// ******************************
`ifndef TRACE_CONSTS_SVH
`define TRACE_CONSTS_SVH

// Data and address width
`define TRACE_XLEN 32
// Register index width
`define TRACE_REG_AW 5
// Low cycle-count bits carried in the header
`define TRACE_CYCLE_W 8

// Words in every record: header, pc, instruction, operand
`define TRACE_FIXED_WORDS 4
// Optional words, one per access mask bit
`define TRACE_MASK_W 4
// Ring buffer size in words, the word index wraps here
`define TRACE_BUF_WORDS 64

// Header field positions
`define TRACE_HDR_CLASS_LSB 0
`define TRACE_HDR_MASK_LSB 4
`define TRACE_HDR_RD_LSB 8
`define TRACE_HDR_RS1_LSB 13
`define TRACE_HDR_RS2_LSB 18
`define TRACE_HDR_CYCLE_LSB 24

`endif

// ==== design/trace_decode.sv ====
// ******************************
// First trace stage: cycle counter, RV32I classifier and access mask
// Registers one retirement, counts retirements lost to back-pressure
// ******************************
`timescale 1ns/1ps
`include "trace_consts.svh"

module trace_decode import trace_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         rvfi_valid,
  input  logic [`TRACE_XLEN-1:0]       rvfi_insn,
  input  logic [`TRACE_XLEN-1:0]       rvfi_pc_rdata,
  input  logic [`TRACE_XLEN-1:0]       rvfi_pc_wdata,
  input  logic [`TRACE_REG_AW-1:0]     rvfi_rs1_addr,
  input  logic [`TRACE_REG_AW-1:0]     rvfi_rs2_addr,
  input  logic [`TRACE_REG_AW-1:0]     rvfi_rd_addr,
  input  logic [`TRACE_XLEN-1:0]       rvfi_rs1_rdata,
  input  logic [`TRACE_XLEN-1:0]       rvfi_rs2_rdata,
  input  logic [`TRACE_XLEN-1:0]       rvfi_rd_wdata,
  input  logic [`TRACE_XLEN-1:0]       rvfi_mem_addr,
  input  logic                         exe_ready,
  output logic                         dec_valid,
  output insn_class_e                  dec_class,
  output access_mask_t                 dec_access,
  output logic [`TRACE_XLEN-1:0]       dec_insn,
  output logic [`TRACE_XLEN-1:0]       dec_pc,
  output logic [`TRACE_XLEN-1:0]       dec_pc_next,
  output logic [`TRACE_REG_AW-1:0]     dec_rs1_addr,
  output logic [`TRACE_REG_AW-1:0]     dec_rs2_addr,
  output logic [`TRACE_REG_AW-1:0]     dec_rd_addr,
  output logic [`TRACE_XLEN-1:0]       dec_rs1_data,
  output logic [`TRACE_XLEN-1:0]       dec_rs2_data,
  output logic [`TRACE_XLEN-1:0]       dec_rd_data,
  output logic [`TRACE_XLEN-1:0]       dec_mem_addr,
  output logic [`TRACE_CYCLE_W-1:0]    dec_cycle,
  output logic [15:0]                  drop_count
);

  logic [`TRACE_CYCLE_W-1:0] cycle_q;
  trace_opcode_e             opcode;
  logic [2:0]                funct3;
  logic [6:0]                funct7;
  insn_class_e               cls;
  access_mask_t              acc;
  logic                      accept;
  logic                      drop;

  assign opcode = trace_opcode_e'(rvfi_insn[6:0]);
  assign funct3 = rvfi_insn[14:12];
  assign funct7 = rvfi_insn[31:25];

  // Zero in the first cycle after reset, only the low bits are kept
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cycle_q <= '0;
    end else begin
      cycle_q <= cycle_q + 1'b1;
    end
  end

  always_comb begin
    cls = CLS_INVALID;
    if (rvfi_insn[1:0] != 2'b11) begin
      cls = CLS_COMPRESSED;
    end else begin
      case (opcode)
        OPC_LUI, OPC_AUIPC: cls = CLS_U;
        OPC_JAL:            cls = CLS_JAL;
        OPC_JALR:           cls = (funct3 == 3'b000) ? CLS_JALR : CLS_INVALID;
        OPC_BRANCH:         cls = (funct3[2:1] == 2'b01) ? CLS_INVALID : CLS_BRANCH;
        // lw is the widest, no ld and no lwu on RV32
        OPC_LOAD:   cls = (funct3 == 3'b011 || funct3[2:1] == 2'b11) ? CLS_INVALID : CLS_LOAD;
        OPC_STORE:  cls = (funct3 < 3'd3) ? CLS_STORE : CLS_INVALID;
        OPC_OP_IMM: begin
          case (funct3)
            3'b001:  cls = (funct7 == 7'h00) ? CLS_SHIFT : CLS_INVALID;
            3'b101:  cls = (funct7 == 7'h00 || funct7 == 7'h20) ? CLS_SHIFT : CLS_INVALID;
            default: cls = CLS_I;
          endcase
        end
        // funct7 0x01 is the M extension, not traced
        OPC_OP: begin
          if (funct7 == 7'h00 || (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
            cls = CLS_R;
          end
        end
        OPC_SYSTEM: begin
          case (funct3)
            3'b000:  cls = CLS_SYSTEM;
            3'b100:  cls = CLS_INVALID;
            default: cls = funct3[2] ? CLS_CSRI : CLS_CSR;
          endcase
        end
        // fence.i has no pred/succ, shown as a plain system record
        OPC_MISC_MEM: begin
          case (funct3)
            3'b000:  cls = CLS_FENCE;
            3'b001:  cls = CLS_SYSTEM;
            default: cls = CLS_INVALID;
          endcase
        end
        default: cls = CLS_INVALID;
      endcase
    end
  end

  // Which data words follow the fixed part of the record
  always_comb begin
    case (cls)
      CLS_R:                               acc = '{mem: 1'b0, rd: 1'b1, rs2: 1'b1, rs1: 1'b1};
      CLS_BRANCH:                          acc = '{mem: 1'b0, rd: 1'b0, rs2: 1'b1, rs1: 1'b1};
      CLS_I, CLS_SHIFT, CLS_JALR, CLS_CSR: acc = '{mem: 1'b0, rd: 1'b1, rs2: 1'b0, rs1: 1'b1};
      CLS_U, CLS_JAL, CLS_CSRI:            acc = '{mem: 1'b0, rd: 1'b1, rs2: 1'b0, rs1: 1'b0};
      CLS_LOAD:                            acc = '{mem: 1'b1, rd: 1'b1, rs2: 1'b0, rs1: 1'b1};
      CLS_STORE:                           acc = '{mem: 1'b1, rd: 1'b0, rs2: 1'b1, rs1: 1'b1};
      default:                             acc = '0;
    endcase
  end

  // Room when empty or when the held record moves on in this cycle
  assign accept = rvfi_valid && (!dec_valid || exe_ready);
  assign drop   = rvfi_valid && dec_valid && !exe_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dec_valid  <= 1'b0;
      drop_count <= '0;
    end else begin
      if (accept) begin
        dec_valid <= 1'b1;
      end else if (exe_ready) begin
        dec_valid <= 1'b0;
      end
      if (drop && drop_count != '1) begin
        drop_count <= drop_count + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      dec_class    <= cls;
      dec_access   <= acc;
      dec_insn     <= rvfi_insn;
      dec_pc       <= rvfi_pc_rdata;
      dec_pc_next  <= rvfi_pc_wdata;
      dec_rs1_addr <= rvfi_rs1_addr;
      dec_rs2_addr <= rvfi_rs2_addr;
      dec_rd_addr  <= rvfi_rd_addr;
      dec_rs1_data <= rvfi_rs1_rdata;
      dec_rs2_data <= rvfi_rs2_rdata;
      dec_rd_data  <= rvfi_rd_wdata;
      dec_mem_addr <= rvfi_mem_addr;
      dec_cycle    <= cycle_q;
    end
  end

  // Drops need a full stage, so an empty one leaves the count alone
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !dec_valid |=> $stable(drop_count));

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    dec_valid && (dec_class == CLS_INVALID || dec_class == CLS_COMPRESSED)
    |-> dec_access == '0);

endmodule

// ==== design/trace_execute.sv ====
// ******************************
// Second trace stage: displayed operand and header word
// Holds one finished record for the Wishbone writer
// ******************************
`timescale 1ns/1ps
`include "trace_consts.svh"

module trace_execute import trace_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         dec_valid,
  input  insn_class_e                  dec_class,
  input  access_mask_t                 dec_access,
  input  logic [`TRACE_XLEN-1:0]       dec_insn,
  input  logic [`TRACE_XLEN-1:0]       dec_pc,
  input  logic [`TRACE_XLEN-1:0]       dec_pc_next,
  input  logic [`TRACE_REG_AW-1:0]     dec_rs1_addr,
  input  logic [`TRACE_REG_AW-1:0]     dec_rs2_addr,
  input  logic [`TRACE_REG_AW-1:0]     dec_rd_addr,
  input  logic [`TRACE_XLEN-1:0]       dec_rs1_data,
  input  logic [`TRACE_XLEN-1:0]       dec_rs2_data,
  input  logic [`TRACE_XLEN-1:0]       dec_rd_data,
  input  logic [`TRACE_XLEN-1:0]       dec_mem_addr,
  input  logic [`TRACE_CYCLE_W-1:0]    dec_cycle,
  input  logic                         res_ready,
  output logic                         exe_ready,
  output logic                         exe_valid,
  output access_mask_t                 exe_access,
  output logic [`TRACE_XLEN-1:0]       exe_header,
  output logic [`TRACE_XLEN-1:0]       exe_pc,
  output logic [`TRACE_XLEN-1:0]       exe_insn,
  output logic [`TRACE_XLEN-1:0]       exe_operand,
  output logic [`TRACE_XLEN-1:0]       exe_rs1_data,
  output logic [`TRACE_XLEN-1:0]       exe_rs2_data,
  output logic [`TRACE_XLEN-1:0]       exe_rd_data,
  output logic [`TRACE_XLEN-1:0]       exe_mem_addr
);

  logic [`TRACE_XLEN-1:0] imm_i;
  logic [`TRACE_XLEN-1:0] imm_s;
  logic [`TRACE_XLEN-1:0] imm_b;
  logic [`TRACE_XLEN-1:0] operand;
  logic [`TRACE_XLEN-1:0] header;
  logic                   accept;

  assign imm_i = {{20{dec_insn[31]}}, dec_insn[31:20]};
  assign imm_s = {{20{dec_insn[31]}}, dec_insn[31:25], dec_insn[11:7]};
  assign imm_b = {{19{dec_insn[31]}}, dec_insn[31], dec_insn[7], dec_insn[30:25],
                  dec_insn[11:8], 1'b0};

  always_comb begin
    case (dec_class)
      CLS_I, CLS_JALR, CLS_LOAD: operand = imm_i;
      CLS_SHIFT:  operand = {27'b0, dec_insn[24:20]};
      CLS_U:      operand = {12'b0, dec_insn[31:12]};
      // Taken or not, the branch shows its target
      CLS_JAL:    operand = dec_pc_next;
      CLS_BRANCH: operand = dec_pc + imm_b;
      CLS_STORE:  operand = imm_s;
      CLS_CSR:    operand = {20'b0, dec_insn[31:20]};
      // uimm in 20:16, CSR address in 11:0
      CLS_CSRI:   operand = {11'b0, dec_insn[19:15], 4'b0, dec_insn[31:20]};
      // pred in 7:4, succ in 3:0
      CLS_FENCE:  operand = {24'b0, dec_insn[27:20]};
      default:    operand = '0;
    endcase
  end

  always_comb begin
    header = '0;
    header[`TRACE_HDR_CLASS_LSB +: $bits(insn_class_e)] = dec_class;
    header[`TRACE_HDR_MASK_LSB +: `TRACE_MASK_W]        = dec_access;
    header[`TRACE_HDR_RD_LSB +: `TRACE_REG_AW]          = dec_rd_addr;
    header[`TRACE_HDR_RS1_LSB +: `TRACE_REG_AW]         = dec_rs1_addr;
    header[`TRACE_HDR_RS2_LSB +: `TRACE_REG_AW]         = dec_rs2_addr;
    header[`TRACE_HDR_CYCLE_LSB +: `TRACE_CYCLE_W]      = dec_cycle;
  end

  assign exe_ready = !exe_valid || res_ready;
  assign accept    = dec_valid && exe_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exe_valid <= 1'b0;
    end else if (accept) begin
      exe_valid <= 1'b1;
    end else if (res_ready) begin
      exe_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      exe_access   <= dec_access;
      exe_header   <= header;
      exe_pc       <= dec_pc;
      exe_insn     <= dec_insn;
      exe_operand  <= operand;
      exe_rs1_data <= dec_rs1_data;
      exe_rs2_data <= dec_rs2_data;
      exe_rd_data  <= dec_rd_data;
      exe_mem_addr <= dec_mem_addr;
    end
  end

  // An offered record stays put until the writer takes it
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    exe_valid && !res_ready |=> exe_valid && $stable(exe_header));

endmodule

// ==== design/trace_pkg.sv ====
// ******************************
// Types shared by the trace encoder stages
// Opcodes, instruction classes and the data access mask
// ******************************
package trace_pkg;

  // RV32I major opcodes
  typedef enum logic [6:0] {
    OPC_LOAD     = 7'b0000011,
    OPC_MISC_MEM = 7'b0001111,
    OPC_OP_IMM   = 7'b0010011,
    OPC_AUIPC    = 7'b0010111,
    OPC_STORE    = 7'b0100011,
    OPC_OP       = 7'b0110011,
    OPC_LUI      = 7'b0110111,
    OPC_BRANCH   = 7'b1100011,
    OPC_JALR     = 7'b1100111,
    OPC_JAL      = 7'b1101111,
    OPC_SYSTEM   = 7'b1110011
  } trace_opcode_e;

  // Format class as written into the record header
  typedef enum logic [3:0] {
    CLS_INVALID    = 4'd0,
    CLS_COMPRESSED = 4'd1,
    CLS_R          = 4'd2,
    CLS_I          = 4'd3,
    CLS_SHIFT      = 4'd4,
    CLS_U          = 4'd5,
    CLS_JAL        = 4'd6,
    CLS_JALR       = 4'd7,
    CLS_BRANCH     = 4'd8,
    CLS_LOAD       = 4'd9,
    CLS_STORE      = 4'd10,
    CLS_CSR        = 4'd11,
    CLS_CSRI       = 4'd12,
    CLS_SYSTEM     = 4'd13,
    CLS_FENCE      = 4'd14
  } insn_class_e;

  // rs1 sits in bit 0, optional words follow from bit 0 upward
  typedef struct packed {
    logic mem;
    logic rd;
    logic rs2;
    logic rs1;
  } access_mask_t;

endpackage

// ==== design/trace_result.sv ====
// ******************************
// Record serializer and Wishbone classic write master
// Writes each record word by word into the ring buffer at BASE_ADDR
// ******************************
`timescale 1ns/1ps
`include "trace_consts.svh"

module trace_result import trace_pkg::*; #(
  parameter logic [`TRACE_XLEN-1:0] BASE_ADDR = '0
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         exe_valid,
  input  access_mask_t                 exe_access,
  input  logic [`TRACE_XLEN-1:0]       exe_header,
  input  logic [`TRACE_XLEN-1:0]       exe_pc,
  input  logic [`TRACE_XLEN-1:0]       exe_insn,
  input  logic [`TRACE_XLEN-1:0]       exe_operand,
  input  logic [`TRACE_XLEN-1:0]       exe_rs1_data,
  input  logic [`TRACE_XLEN-1:0]       exe_rs2_data,
  input  logic [`TRACE_XLEN-1:0]       exe_rd_data,
  input  logic [`TRACE_XLEN-1:0]       exe_mem_addr,
  input  logic                         wb_ack,
  output logic                         res_ready,
  output logic                         wb_cyc,
  output logic                         wb_stb,
  output logic                         wb_we,
  output logic [3:0]                   wb_sel,
  output logic [`TRACE_XLEN-1:0]       wb_adr,
  output logic [`TRACE_XLEN-1:0]       wb_dat_o
);

  localparam int Slots = `TRACE_FIXED_WORDS + `TRACE_MASK_W;
  localparam int SlotW = $clog2(Slots);
  localparam int IdxW  = $clog2(`TRACE_BUF_WORDS);

  logic [`TRACE_XLEN-1:0] rec_q [Slots];
  access_mask_t           mask_q;
  logic                   busy_q;
  logic [SlotW-1:0]       slot_q;
  logic [SlotW-1:0]       slot_next;
  logic                   last_word;
  logic [Slots-1:0]       slot_en;
  logic [IdxW-1:0]        widx_q;
  logic                   accept;

  assign res_ready = !busy_q;
  assign accept    = exe_valid && !busy_q;

  // Fixed words always go out, masked words only when their bit is set
  assign slot_en = {mask_q, {`TRACE_FIXED_WORDS{1'b1}}};

  // Nearest enabled slot above the current one
  always_comb begin
    slot_next = slot_q;
    last_word = 1'b1;
    for (int i = Slots - 1; i > 0; i--) begin
      if (i > int'(slot_q) && slot_en[i]) begin
        slot_next = SlotW'(i);
        last_word = 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      slot_q <= '0;
      widx_q <= '0;
    end else if (!busy_q) begin
      if (exe_valid) begin
        busy_q <= 1'b1;
        slot_q <= '0;
      end
    end else if (wb_ack) begin
      widx_q <= (widx_q == IdxW'(`TRACE_BUF_WORDS - 1)) ? '0 : widx_q + 1'b1;
      slot_q <= slot_next;
      // Final ack ends the cycle, one idle cycle follows
      if (last_word) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rec_q[0] <= exe_header;
      rec_q[1] <= exe_pc;
      rec_q[2] <= exe_insn;
      rec_q[3] <= exe_operand;
      rec_q[4] <= exe_rs1_data;
      rec_q[5] <= exe_rs2_data;
      rec_q[6] <= exe_rd_data;
      rec_q[7] <= exe_mem_addr;
      mask_q   <= exe_access;
    end
  end

  assign wb_cyc   = busy_q;
  assign wb_stb   = busy_q;
  assign wb_we    = 1'b1;
  assign wb_sel   = 4'hf;
  assign wb_dat_o = rec_q[slot_q];
  assign wb_adr   = BASE_ADDR + {{(`TRACE_XLEN - IdxW - 2){1'b0}}, widx_q, 2'b00};

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_stb |-> wb_cyc);

  // Classic cycle: the slave may sample any time before its ack
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_dat_o));

endmodule

// ==== flist.f ====
+incdir+design
design/trace_pkg.sv
design/trace_decode.sv
design/trace_execute.sv
design/trace_result.sv
design/rvfi_trace_top.sv
tb/tb_rvfi_trace.sv

// ==== run.sh ====
#!/bin/sh
# Build the trace encoder testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rvfi_trace -f flist.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Regression passed"; then
  exit 0
fi
exit 1

// ==== tb/tb_rvfi_trace.sv ====
// ******************************
// Testbench for the RVFI trace encoder
// Drives directed retirements, models the Wishbone memory
// and compares every buffer write with a reference record model
// ******************************
`timescale 1ns/1ps
`include "trace_consts.svh"

module tb_rvfi_trace import trace_pkg::*; ();

  localparam logic [31:0] BASE_ADDR = 32'h8000_0400;

  // About 40 records of at most 8 words with up to 4 wait states per word
  localparam int NUM_RECORDS    = 40;
  localparam int MAX_WORDS      = `TRACE_FIXED_WORDS + 4;
  localparam int MAX_WAIT       = 4;
  // Margin covers reset, pipeline fill, settle waits and the forced stall
  localparam int TIMEOUT_CYCLES = NUM_RECORDS * MAX_WORDS * (MAX_WAIT + 1) + 400;

  logic        clk_i;
  logic        rst_ni;
  logic        rvfi_valid;
  logic [31:0] rvfi_insn;
  logic [31:0] rvfi_pc_rdata;
  logic [31:0] rvfi_pc_wdata;
  logic [4:0]  rvfi_rs1_addr;
  logic [4:0]  rvfi_rs2_addr;
  logic [4:0]  rvfi_rd_addr;
  logic [31:0] rvfi_rs1_rdata;
  logic [31:0] rvfi_rs2_rdata;
  logic [31:0] rvfi_rd_wdata;
  logic [31:0] rvfi_mem_addr;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [3:0]  wb_sel;
  logic [31:0] wb_adr;
  logic [31:0] wb_dat_o;
  logic        wb_ack;
  logic [15:0] drop_count;

  logic [31:0] exp_adr[$];
  logic [31:0] exp_dat[$];
  logic [31:0] got_adr[$];
  logic [31:0] got_dat[$];
  int          widx;
  logic [31:0] pc_q;
  logic [31:0] data_rng;
  logic [31:0] mem_rng;
  int          wait_left;
  bit          stall_ack;
  logic [31:0] cyc_cnt;
  int          cycles;
  int          checks;
  int          errors;

  rvfi_trace_top #(
    .BASE_ADDR(BASE_ADDR)
  ) u_dut (.*);

  always #10 clk_i = ~clk_i;

  // Cycle count that is zero in the first cycle after reset
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cyc_cnt <= '0;
    end else begin
      cyc_cnt <= cyc_cnt + 32'd1;
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("TIMEOUT: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Done: %0d checks, %0d errors", checks, errors);
      $display("Regression failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED time %0t: %s expected 0x%08h actual 0x%08h",
               $time, name, expected, actual);
    end
  endtask

  // Wishbone memory with 0 to 3 wait states per word and a forced stall
  always @(negedge clk_i) begin
    if (!rst_ni || !wb_stb || stall_ack) begin
      wb_ack <= 1'b0;
    end else if (wait_left == 0) begin
      wb_ack <= 1'b1;
      got_adr.push_back(wb_adr);
      got_dat.push_back(wb_dat_o);
      check_value("wb_cyc", 32'd1, 32'(wb_cyc));
      check_value("wb_we", 32'd1, 32'(wb_we));
      check_value("wb_sel", 32'hf, 32'(wb_sel));
      mem_rng = lcg_step(mem_rng);
      wait_left = int'(mem_rng[17:16]);
    end else begin
      wb_ack <= 1'b0;
      wait_left = wait_left - 1;
    end
  end

  task automatic hold_ack(input bit on);
    stall_ack = on;
  endtask

  // Expected record for the retirement now on the RVFI inputs
  task automatic add_expected(input insn_class_e cls, input logic [7:0] cycle);
    logic [31:0] insn;
    logic [3:0]  mask;
    logic [31:0] operand;
    logic [31:0] words [8];
    int          n;
    insn = rvfi_insn;
    // Mask bits from 0 up are rs1, rs2, rd and mem
    case (cls)
      CLS_R:                               mask = 4'b0111;
      CLS_BRANCH:                          mask = 4'b0011;
      CLS_I, CLS_SHIFT, CLS_JALR, CLS_CSR: mask = 4'b0101;
      CLS_U, CLS_JAL, CLS_CSRI:            mask = 4'b0100;
      CLS_LOAD:                            mask = 4'b1101;
      CLS_STORE:                           mask = 4'b1011;
      default:                             mask = 4'b0000;
    endcase
    case (cls)
      CLS_I, CLS_JALR, CLS_LOAD: operand = {{20{insn[31]}}, insn[31:20]};
      CLS_SHIFT:  operand = 32'(insn[24:20]);
      CLS_U:      operand = insn >> 12;
      CLS_JAL:    operand = rvfi_pc_wdata;
      CLS_BRANCH: operand = rvfi_pc_rdata +
                            {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
      CLS_STORE:  operand = {{20{insn[31]}}, insn[31:25], insn[11:7]};
      CLS_CSR:    operand = 32'(insn[31:20]);
      CLS_CSRI:   operand = (32'(insn[19:15]) << 16) | 32'(insn[31:20]);
      CLS_FENCE:  operand = 32'(insn[27:20]);
      default:    operand = 32'h0;
    endcase
    words[0] = {cycle, 1'b0, rvfi_rs2_addr, rvfi_rs1_addr, rvfi_rd_addr, mask, 4'(cls)};
    words[1] = rvfi_pc_rdata;
    words[2] = insn;
    words[3] = operand;
    n = 4;
    if (mask[0]) begin
      words[n] = rvfi_rs1_rdata;
      n++;
    end
    if (mask[1]) begin
      words[n] = rvfi_rs2_rdata;
      n++;
    end
    if (mask[2]) begin
      words[n] = rvfi_rd_wdata;
      n++;
    end
    if (mask[3]) begin
      words[n] = rvfi_mem_addr;
      n++;
    end
    for (int i = 0; i < n; i++) begin
      exp_adr.push_back(BASE_ADDR + 32'(widx) * 32'd4);
      exp_dat.push_back(words[i]);
      widx = (widx + 1) % `TRACE_BUF_WORDS;
    end
  endtask

  // Drives one retirement for one clock edge just after a falling edge
  task automatic retire(input logic [31:0] insn, input insn_class_e cls,
                        input logic [31:0] pc, input logic [31:0] pc_next, input bit keep);
    rvfi_valid    = 1'b1;
    rvfi_insn     = insn;
    rvfi_pc_rdata = pc;
    rvfi_pc_wdata = pc_next;
    rvfi_rs1_addr = insn[19:15];
    rvfi_rs2_addr = insn[24:20];
    rvfi_rd_addr  = insn[11:7];
    data_rng = lcg_step(data_rng);
    rvfi_rs1_rdata = data_rng;
    data_rng = lcg_step(data_rng);
    rvfi_rs2_rdata = data_rng;
    data_rng = lcg_step(data_rng);
    rvfi_rd_wdata = data_rng;
    data_rng = lcg_step(data_rng);
    rvfi_mem_addr = data_rng;
    if (keep) begin
      add_expected(cls, cyc_cnt[7:0]);
    end
    @(negedge clk_i);
    rvfi_valid = 1'b0;
  endtask

  task automatic wait_drained();
    while (got_adr.size() < exp_adr.size()) begin
      @(negedge clk_i);
    end
  endtask

  task automatic send_at(input logic [31:0] insn, input insn_class_e cls,
                         input logic [31:0] pc, input logic [31:0] pc_next);
    retire(insn, cls, pc, pc_next, 1'b1);
    wait_drained();
  endtask

  task automatic send(input logic [31:0] insn, input insn_class_e cls);
    send_at(insn, cls, pc_q, pc_q + 32'd4);
    pc_q = pc_q + 32'd4;
  endtask

  task automatic check_buffer();
    int n;
    wait_drained();
    repeat (8) @(negedge clk_i);
    if (got_adr.size() != exp_adr.size()) begin
      errors++;
      $display("ERROR time %0t: expected %0d buffer writes but saw %0d",
               $time, exp_adr.size(), got_adr.size());
    end
    n = (got_adr.size() < exp_adr.size()) ? got_adr.size() : exp_adr.size();
    for (int i = 0; i < n; i++) begin
      check_value($sformatf("wb_adr word %0d", i), exp_adr[i], got_adr[i]);
      check_value($sformatf("wb_dat_o word %0d", i), exp_dat[i], got_dat[i]);
    end
    exp_adr.delete();
    exp_dat.delete();
    got_adr.delete();
    got_dat.delete();
  endtask

  task automatic alu_records();
    send(32'h002081B3, CLS_R);        // add x3, x1, x2
    send(32'h407302B3, CLS_R);        // sub x5, x6, x7
    send(32'h023100B3, CLS_INVALID);  // mul from the M extension is not traced
    send(32'hFFB58513, CLS_I);        // addi x10, x11, -5
    send(32'h07F27213, CLS_I);        // andi x4, x4, 0x7f
    send(32'h00D31313, CLS_SHIFT);    // slli x6, x6, 13
    send(32'h41F4D413, CLS_SHIFT);    // srai x8, x9, 31
    check_buffer();
  endtask

  task automatic memory_records();
    send(32'hFF812603, CLS_LOAD);     // lw x12, -8(x2)
    send(32'hFE942623, CLS_STORE);    // sw x9, -20(x8)
    send(32'h00013083, CLS_INVALID);  // load funct3 011
    send(32'h00323023, CLS_INVALID);  // store funct3 3
    check_buffer();
  endtask

  task automatic control_flow_records();
    send_at(32'h00208863, CLS_BRANCH, 32'h0000_0300, 32'h0000_0310);  // beq +16
    send_at(32'hFE4190E3, CLS_BRANCH, 32'h0000_0400, 32'h0000_0404);  // bne -32
    send_at(32'h001000EF, CLS_JAL, 32'h0000_0200, 32'h0000_0A00);     // jal x1, +2048
    send_at(32'h00C08067, CLS_JALR, 32'h0000_0A00, 32'h1234_0010);    // jalr x0, 12(x1)
    send(32'hABCDE2B7, CLS_U);        // lui x5, 0xabcde
    send(32'h00012397, CLS_U);        // auipc x7, 0x12
    check_buffer();
  endtask

  task automatic csr_system_records();
    send(32'h30019173, CLS_CSR);         // csrrw x2, mstatus, x3
    send(32'h3042E273, CLS_CSRI);        // csrrsi x4, mie, 5
    send(32'h0F50000F, CLS_FENCE);       // fence iorw, ow
    send(32'h00000073, CLS_SYSTEM);      // ecall
    send(32'h00000085, CLS_COMPRESSED);  // c.addi x1, 1
    check_buffer();
  endtask

  // Three retirements fill the stalled stages and the fourth is lost
  task automatic back_pressure_drop();
    check_value("drop_count", 32'd0, 32'(drop_count));
    hold_ack(1'b1);
    for (int i = 0; i < 4; i++) begin
      retire(32'h00108093, CLS_I, pc_q, pc_q + 32'd4, i < 3);
      pc_q = pc_q + 32'd4;
    end
    repeat (20) @(negedge clk_i);
    check_value("drop_count", 32'd1, 32'(drop_count));
    hold_ack(1'b0);
    check_buffer();
  endtask

  task automatic ring_wrap();
    bit wrapped;
    wrapped = 1'b0;
    // 10 records of 7 words pass the 64-word boundary at least once
    for (int i = 0; i < 10; i++) begin
      send({12'h002, 5'd1, 3'b000, 5'(i + 1), 7'h33}, CLS_R);
    end
    wait_drained();
    foreach (got_adr[i]) begin
      if (got_adr[i] == BASE_ADDR) begin
        wrapped = 1'b1;
      end
    end
    if (!wrapped) begin
      errors++;
      $display("ERROR time %0t: write address never returned to the buffer base", $time);
    end
    check_buffer();
  endtask

  initial begin
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    rvfi_valid     = 1'b0;
    rvfi_insn      = '0;
    rvfi_pc_rdata  = '0;
    rvfi_pc_wdata  = '0;
    rvfi_rs1_addr  = '0;
    rvfi_rs2_addr  = '0;
    rvfi_rd_addr   = '0;
    rvfi_rs1_rdata = '0;
    rvfi_rs2_rdata = '0;
    rvfi_rd_wdata  = '0;
    rvfi_mem_addr  = '0;
    wb_ack         = 1'b0;
    widx           = 0;
    pc_q           = 32'h0000_0100;
    data_rng       = 32'd85;
    mem_rng        = 32'd85;
    wait_left      = 0;
    stall_ack      = 1'b0;
    cycles         = 0;
    checks         = 0;
    errors         = 0;

    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_value("wb_cyc", 32'd0, 32'(wb_cyc));
    check_value("wb_stb", 32'd0, 32'(wb_stb));
    check_value("drop_count", 32'd0, 32'(drop_count));
    check_value("wb_adr", BASE_ADDR, wb_adr);

    alu_records();
    memory_records();
    control_flow_records();
    csr_system_records();
    back_pressure_drop();
    ring_wrap();

    repeat (5) @(negedge clk_i);
    $display("Done: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule
